/* hdl/eth_stats_pkg.sv */
// Ethernet statistics types
`default_nettype none

package eth_stats_pkg;

	// Every total is one 64-bit word
	localparam int stat_width = 64;

	// Width of the log stream data
	localparam int log_width = 64;

	// Frame length in bytes, enough for jumbo frames
	typedef logic [16:0] frame_len_t;

	// Wrapping change counter, one per direction
	typedef logic [2:0] stats_id_t;

	// Beats of one log record, in the order they are sent
	typedef enum logic [2:0] {
		beat_header,
		beat_time,
		beat_tx_bytes,
		beat_tx_good,
		beat_tx_bad,
		beat_rx_bytes,
		beat_rx_good,
		beat_rx_bad
	} log_beat_t;

endpackage

`default_nettype wire

/* hdl/axil_pkg.sv */
// AXI4-Lite register map
`default_nettype none

package axil_pkg;

	localparam int axil_data_width = 32;

	typedef enum logic [1:0] {
		resp_okay = 2'b00,
		resp_slverr = 2'b10
	} axil_resp_t;

	// Byte addresses, totals as low word then high word
	typedef enum logic [11:0] {
		addr_ctrl = 12'h000,
		addr_sample_period = 12'h004,
		addr_log_id = 12'h008,
		addr_overflow = 12'h00C,
		addr_tx_bytes_lo = 12'h010,
		addr_tx_bytes_hi = 12'h014,
		addr_tx_good_lo = 12'h018,
		addr_tx_good_hi = 12'h01C,
		addr_tx_bad_lo = 12'h020,
		addr_tx_bad_hi = 12'h024,
		addr_rx_bytes_lo = 12'h028,
		addr_rx_bytes_hi = 12'h02C,
		addr_rx_good_lo = 12'h030,
		addr_rx_good_hi = 12'h034,
		addr_rx_bad_lo = 12'h038,
		addr_rx_bad_hi = 12'h03C
	} reg_addr_t;

endpackage

`default_nettype wire

/* hdl/eth_stats_if.sv */
// Per-direction statistics bundle
`timescale 1ns/10ps
`default_nettype none

interface eth_stats_if import eth_stats_pkg::*; ();

	logic [stat_width-1:0] total_bytes;
	logic [stat_width-1:0] total_good;
	logic [stat_width-1:0] total_bad;
	// Bumps on every counted frame
	stats_id_t stats_id;

	modport source (output total_bytes, total_good, total_bad, stats_id);

	modport sink (input total_bytes, total_good, total_bad, stats_id);

endinterface

`default_nettype wire

/* hdl/eth_frame_meter.sv */
// Ethernet frame length meter
`timescale 1ns/10ps
`default_nettype none

module eth_frame_meter import eth_stats_pkg::*; #(
	parameter bit HAS_READY = 1
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic clear,

	input wire logic tvalid,
	input wire logic tready,
	input wire logic tlast,
	input wire logic tuser,

	output frame_len_t frame_bytes,
	output logic frame_good,
	output logic valid
);
	logic beat;
	frame_len_t beat_count;
	frame_len_t next_count;

	// Without tready every valid beat is taken by the sink
	assign beat = tvalid && (!HAS_READY || tready);

	// One byte per beat, held at the top of the range
	assign next_count = (&beat_count) ? beat_count : beat_count + 1'b1;

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			beat_count <= '0;
			valid <= 1'b0;
		end else begin
			valid <= beat && tlast;
			if (beat) begin
				beat_count <= tlast ? '0 : next_count;
			end
		end
	end

	// Result of the finished frame
	always_ff @(posedge clk) begin
		if (beat && tlast) begin
			frame_bytes <= next_count;
			frame_good <= !tuser;
		end
	end

	// Minimum Ethernet frame is far longer than one beat
	assert property (@(posedge clk) disable iff (reset) valid |=> !valid)
		else $error("frame meter valid high for two cycles");

endmodule

`default_nettype wire

/* hdl/eth_stats_accum.sv */
// Per-direction traffic totals
`timescale 1ns/10ps
`default_nettype none

module eth_stats_accum import eth_stats_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic clear,
	input wire logic enable,

	input wire frame_len_t frame_bytes,
	input wire logic frame_good,
	input wire logic valid,

	eth_stats_if.source stats
);
	logic count_frame;

	// Frames seen while disabled leave no trace
	assign count_frame = valid && enable;

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			stats.total_bytes <= '0;
			stats.total_good <= '0;
			stats.total_bad <= '0;
			stats.stats_id <= '0;
		end else if (count_frame) begin
			stats.total_bytes <= stats.total_bytes + stat_width'(frame_bytes);
			if (frame_good) begin
				stats.total_good <= stats.total_good + 1'b1;
			end else begin
				stats.total_bad <= stats.total_bad + 1'b1;
			end
			// Logger watches this to spot new data
			stats.stats_id <= stats.stats_id + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hdl/eth_stats_regs.sv */
// Statistics register block
`timescale 1ns/10ps
`default_nettype none

module eth_stats_regs import axil_pkg::*, eth_stats_pkg::*; (
	input wire logic clk,
	input wire logic reset,

	input wire logic [11:0] awaddr,
	input wire logic awvalid,
	output logic awready,
	input wire logic [axil_data_width-1:0] wdata,
	input wire logic [axil_data_width/8-1:0] wstrb,
	input wire logic wvalid,
	output logic wready,

	output axil_resp_t bresp,
	output logic bvalid,
	input wire logic bready,

	input wire logic [11:0] araddr,
	input wire logic arvalid,
	output logic arready,
	output logic [axil_data_width-1:0] rdata,
	output axil_resp_t rresp,
	output logic rvalid,
	input wire logic rready,

	output logic enable,
	output logic clear,
	output logic log_enable,
	output logic [31:0] sample_period,
	output logic [15:0] log_id,

	input wire logic [31:0] overflow,
	eth_stats_if.sink tx_stats,
	eth_stats_if.sink rx_stats
);
	logic wr_accept;
	logic rd_accept;
	axil_resp_t wr_resp;
	axil_resp_t rd_resp;
	logic [axil_data_width-1:0] rd_data;
	logic [stat_width-axil_data_width-1:0] shadow;
	logic [stat_width-axil_data_width-1:0] shadow_next;

	// One transaction in flight per channel
	assign wr_accept = awvalid && wvalid && !bvalid;
	assign awready = wr_accept;
	assign wready = wr_accept;
	assign rd_accept = arvalid && !rvalid;
	assign arready = rd_accept;

	// Totals and overflow accept writes but ignore them
	always_comb begin
		wr_resp = resp_okay;
		if (awaddr > addr_rx_bad_hi || awaddr[1:0] != 2'b00) begin
			wr_resp = resp_slverr;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			enable <= 1'b0;
			clear <= 1'b0;
			log_enable <= 1'b0;
			sample_period <= '0;
			log_id <= '0;
			bvalid <= 1'b0;
			bresp <= resp_okay;
		end else begin
			// Clear lasts a single cycle
			clear <= 1'b0;
			if (wr_accept) begin
				bvalid <= 1'b1;
				bresp <= wr_resp;
				case (reg_addr_t'(awaddr))
					addr_ctrl: begin
						enable <= wdata[0];
						clear <= wdata[1];
						log_enable <= wdata[2];
					end
					addr_sample_period: sample_period <= wdata;
					addr_log_id: log_id <= wdata[15:0];
					default: ;
				endcase
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// Low half read latches the upper word for the following high read
	always_comb begin
		rd_data = '0;
		rd_resp = resp_okay;
		shadow_next = shadow;
		case (reg_addr_t'(araddr))
			addr_ctrl: rd_data[2:0] = {log_enable, 1'b0, enable};
			addr_sample_period: rd_data = sample_period;
			addr_log_id: rd_data[15:0] = log_id;
			addr_overflow: rd_data = overflow;
			addr_tx_bytes_lo: {shadow_next, rd_data} = tx_stats.total_bytes;
			addr_tx_good_lo: {shadow_next, rd_data} = tx_stats.total_good;
			addr_tx_bad_lo: {shadow_next, rd_data} = tx_stats.total_bad;
			addr_rx_bytes_lo: {shadow_next, rd_data} = rx_stats.total_bytes;
			addr_rx_good_lo: {shadow_next, rd_data} = rx_stats.total_good;
			addr_rx_bad_lo: {shadow_next, rd_data} = rx_stats.total_bad;
			addr_tx_bytes_hi, addr_tx_good_hi, addr_tx_bad_hi,
			addr_rx_bytes_hi, addr_rx_good_hi, addr_rx_bad_hi: rd_data = shadow;
			default: rd_resp = resp_slverr;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rvalid <= 1'b0;
			shadow <= '0;
		end else if (rd_accept) begin
			rvalid <= 1'b1;
			shadow <= shadow_next;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_accept) begin
			rdata <= rd_data;
			rresp <= rd_resp;
		end
	end

	assert property (@(posedge clk) disable iff (reset) bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else $error("read response changed before rready");

endmodule

`default_nettype wire

/* hdl/eth_stats_logger.sv */
// Statistics log record writer
`timescale 1ns/10ps
`default_nettype none

module eth_stats_logger import eth_stats_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic clear,
	input wire logic log_enable,
	input wire logic [31:0] sample_period,
	input wire logic [15:0] log_id,
	input wire logic [63:0] current_time,

	eth_stats_if.sink tx_stats,
	eth_stats_if.sink rx_stats,

	output logic [31:0] overflow,
	output logic [log_width-1:0] tdata,
	output logic tlast,
	output logic tvalid,
	input wire logic tready
);
	logic [31:0] sample_timer;
	stats_id_t tx_id_prev;
	stats_id_t rx_id_prev;
	logic changed;
	logic accept;
	logic start;
	log_beat_t beat;
	logic [log_width-1:0] record [8];

	// Changes closer together than the sample period are ignored
	assign accept = changed && sample_timer >= sample_period;
	assign start = accept && log_enable && !tvalid;

	always_ff @(posedge clk) begin
		if (reset || clear || accept) begin
			sample_timer <= '0;
		end else if (!(&sample_timer)) begin
			sample_timer <= sample_timer + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			tx_id_prev <= '0;
			rx_id_prev <= '0;
			changed <= 1'b0;
		end else begin
			tx_id_prev <= tx_stats.stats_id;
			rx_id_prev <= rx_stats.stats_id;
			changed <= tx_stats.stats_id != tx_id_prev || rx_stats.stats_id != rx_id_prev;
		end
	end

	// Beat sequencer, a record is dropped while one is still going out
	always_ff @(posedge clk) begin
		if (reset) begin
			tvalid <= 1'b0;
			beat <= beat_header;
			overflow <= '0;
		end else begin
			if (clear) begin
				overflow <= '0;
			end else if (accept && tvalid) begin
				overflow <= overflow + 1'b1;
			end
			if (tvalid) begin
				if (tready && beat == beat_rx_bad) begin
					tvalid <= 1'b0;
					beat <= beat_header;
				end else if (tready) begin
					beat <= log_beat_t'(beat + 1'b1);
				end
			end else if (start) begin
				tvalid <= 1'b1;
				beat <= beat_header;
			end
		end
	end

	// Snapshot of the whole record at start
	always_ff @(posedge clk) begin
		if (start) begin
			record[beat_header] <= {log_id, 16'd0, overflow};
			record[beat_time] <= current_time;
			record[beat_tx_bytes] <= tx_stats.total_bytes;
			record[beat_tx_good] <= tx_stats.total_good;
			record[beat_tx_bad] <= tx_stats.total_bad;
			record[beat_rx_bytes] <= rx_stats.total_bytes;
			record[beat_rx_good] <= rx_stats.total_good;
			record[beat_rx_bad] <= rx_stats.total_bad;
		end
	end

	assign tdata = record[beat];
	assign tlast = tvalid && beat == beat_rx_bad;

	assert property (@(posedge clk) disable iff (reset)
		tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tlast))
		else $error("log beat changed while stalled");

endmodule

`default_nettype wire

/* hdl/eth_stats_collector.sv */
// Ethernet statistics collector
`timescale 1ns/10ps
`default_nettype none

module eth_stats_collector import axil_pkg::*, eth_stats_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic [63:0] current_time,

	input wire logic [11:0] s_axi_awaddr,
	input wire logic s_axi_awvalid,
	output logic s_axi_awready,
	input wire logic [axil_data_width-1:0] s_axi_wdata,
	input wire logic [axil_data_width/8-1:0] s_axi_wstrb,
	input wire logic s_axi_wvalid,
	output logic s_axi_wready,
	output logic [1:0] s_axi_bresp,
	output logic s_axi_bvalid,
	input wire logic s_axi_bready,
	input wire logic [11:0] s_axi_araddr,
	input wire logic s_axi_arvalid,
	output logic s_axi_arready,
	output logic [axil_data_width-1:0] s_axi_rdata,
	output logic [1:0] s_axi_rresp,
	output logic s_axi_rvalid,
	input wire logic s_axi_rready,

	output logic [log_width-1:0] m_axis_log_tdata,
	output logic m_axis_log_tlast,
	output logic m_axis_log_tvalid,
	input wire logic m_axis_log_tready,

	input wire logic axis_tx_tready,
	input wire logic axis_tx_tvalid,
	input wire logic axis_tx_tlast,
	input wire logic axis_tx_tuser,

	input wire logic axis_rx_tvalid,
	input wire logic axis_rx_tlast,
	input wire logic axis_rx_tuser
);
	logic enable;
	logic clear;
	logic log_enable;
	logic [31:0] sample_period;
	logic [15:0] log_id;
	logic [31:0] overflow;

	frame_len_t tx_frame_bytes;
	logic tx_frame_good;
	logic tx_valid;
	frame_len_t rx_frame_bytes;
	logic rx_frame_good;
	logic rx_valid;

	eth_stats_if tx_stats ();
	eth_stats_if rx_stats ();

	// Transmit side, only beats taken by the MAC count
	eth_frame_meter #(.HAS_READY(1)) u_tx_meter (
		.clk(clk), .reset(reset), .clear(clear),
		.tvalid(axis_tx_tvalid), .tready(axis_tx_tready),
		.tlast(axis_tx_tlast), .tuser(axis_tx_tuser),
		.frame_bytes(tx_frame_bytes), .frame_good(tx_frame_good), .valid(tx_valid)
	);

	eth_stats_accum u_tx_accum (
		.clk(clk), .reset(reset), .clear(clear), .enable(enable),
		.frame_bytes(tx_frame_bytes), .frame_good(tx_frame_good), .valid(tx_valid),
		.stats(tx_stats)
	);

	// Receive side has no back-pressure
	eth_frame_meter #(.HAS_READY(0)) u_rx_meter (
		.clk(clk), .reset(reset), .clear(clear),
		.tvalid(axis_rx_tvalid), .tready(1'b1),
		.tlast(axis_rx_tlast), .tuser(axis_rx_tuser),
		.frame_bytes(rx_frame_bytes), .frame_good(rx_frame_good), .valid(rx_valid)
	);

	eth_stats_accum u_rx_accum (
		.clk(clk), .reset(reset), .clear(clear), .enable(enable),
		.frame_bytes(rx_frame_bytes), .frame_good(rx_frame_good), .valid(rx_valid),
		.stats(rx_stats)
	);

	eth_stats_regs u_regs (
		.clk(clk), .reset(reset),
		.awaddr(s_axi_awaddr), .awvalid(s_axi_awvalid), .awready(s_axi_awready),
		.wdata(s_axi_wdata), .wstrb(s_axi_wstrb), .wvalid(s_axi_wvalid),
		.wready(s_axi_wready),
		.bresp(s_axi_bresp), .bvalid(s_axi_bvalid), .bready(s_axi_bready),
		.araddr(s_axi_araddr), .arvalid(s_axi_arvalid), .arready(s_axi_arready),
		.rdata(s_axi_rdata), .rresp(s_axi_rresp), .rvalid(s_axi_rvalid),
		.rready(s_axi_rready),
		.enable(enable), .clear(clear), .log_enable(log_enable),
		.sample_period(sample_period), .log_id(log_id),
		.overflow(overflow), .tx_stats(tx_stats), .rx_stats(rx_stats)
	);

	eth_stats_logger u_logger (
		.clk(clk), .reset(reset), .clear(clear), .log_enable(log_enable),
		.sample_period(sample_period), .log_id(log_id), .current_time(current_time),
		.tx_stats(tx_stats), .rx_stats(rx_stats), .overflow(overflow),
		.tdata(m_axis_log_tdata), .tlast(m_axis_log_tlast),
		.tvalid(m_axis_log_tvalid), .tready(m_axis_log_tready)
	);

endmodule

`default_nettype wire

/* verif/eth_stats_tb.sv */
// Statistics collector testbench
`timescale 1ns/10ps
`default_nettype none

module eth_stats_tb import axil_pkg::*, eth_stats_pkg::*; ();
	localparam int half_period = 50;
	localparam int sample_delay = 25;
	localparam int wait_limit = 200;

	logic clk;
	logic reset;
	logic [63:0] current_time;
	logic [11:0] s_axi_awaddr;
	logic s_axi_awvalid;
	logic s_axi_awready;
	logic [axil_data_width-1:0] s_axi_wdata;
	logic [axil_data_width/8-1:0] s_axi_wstrb;
	logic s_axi_wvalid;
	logic s_axi_wready;
	logic [1:0] s_axi_bresp;
	logic s_axi_bvalid;
	logic s_axi_bready;
	logic [11:0] s_axi_araddr;
	logic s_axi_arvalid;
	logic s_axi_arready;
	logic [axil_data_width-1:0] s_axi_rdata;
	logic [1:0] s_axi_rresp;
	logic s_axi_rvalid;
	logic s_axi_rready;
	logic [log_width-1:0] m_axis_log_tdata;
	logic m_axis_log_tlast;
	logic m_axis_log_tvalid;
	logic m_axis_log_tready;
	logic axis_tx_tready;
	logic axis_tx_tvalid;
	logic axis_tx_tlast;
	logic axis_tx_tuser;
	logic axis_rx_tvalid;
	logic axis_rx_tlast;
	logic axis_rx_tuser;

	// Expected record beats and the last seen time beat
	logic [log_width-1:0] beat_exp [8];
	logic [63:0] last_time;
	logic [stat_width-1:0] preset_value;

	eth_stats_collector i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// Free-running time base
	initial begin
		current_time = '0;
		forever begin
			@(negedge clk);
			current_time = current_time + 1'b1;
		end
	end

	task automatic stop_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			stop_run();
		end
	endtask

	task automatic give_up(input string what);
		$display("Timeout: %s never came", what);
		stop_run();
	endtask

	task automatic need_fields(input int got, input int want, input int line_no);
		if (got != want) begin
			$display("Trace line %0d has %0d fields instead of %0d", line_no, got, want);
			stop_run();
		end
	endtask

	task automatic reg_write(input string name, input logic [11:0] addr,
			input logic [31:0] data);
		int waited;
		waited = 0;
		@(negedge clk);
		s_axi_awaddr = addr;
		s_axi_wdata = data;
		s_axi_awvalid = 1'b1;
		s_axi_wvalid = 1'b1;
		#sample_delay;
		while (!s_axi_awready) begin
			waited++;
			if (waited > wait_limit) give_up("awready for a register write");
			@(negedge clk);
			#sample_delay;
		end
		check({name, " wready"}, 1, s_axi_wready);
		@(negedge clk);
		s_axi_awvalid = 1'b0;
		s_axi_wvalid = 1'b0;
		waited = 0;
		while (!s_axi_bvalid) begin
			waited++;
			if (waited > wait_limit) give_up("bvalid for a register write");
			@(negedge clk);
		end
		// Response has to wait for bready
		@(negedge clk);
		check({name, " bvalid hold"}, 1, s_axi_bvalid);
		check({name, " bresp"}, resp_okay, s_axi_bresp);
		s_axi_bready = 1'b1;
		@(negedge clk);
		s_axi_bready = 1'b0;
	endtask

	task automatic reg_read(input string name, input logic [11:0] addr,
			input logic [31:0] exp_data, input logic [1:0] exp_resp);
		int waited;
		waited = 0;
		@(negedge clk);
		s_axi_araddr = addr;
		s_axi_arvalid = 1'b1;
		#sample_delay;
		while (!s_axi_arready) begin
			waited++;
			if (waited > wait_limit) give_up("arready for a register read");
			@(negedge clk);
			#sample_delay;
		end
		@(negedge clk);
		s_axi_arvalid = 1'b0;
		waited = 0;
		while (!s_axi_rvalid) begin
			waited++;
			if (waited > wait_limit) give_up("rvalid for a register read");
			@(negedge clk);
		end
		// Read data has to wait for rready
		@(negedge clk);
		check({name, " rvalid hold"}, 1, s_axi_rvalid);
		check({name, " rdata"}, exp_data, s_axi_rdata);
		check({name, " rresp"}, exp_resp, s_axi_rresp);
		s_axi_rready = 1'b1;
		@(negedge clk);
		s_axi_rready = 1'b0;
	endtask

	// Random gaps, plus random tready on the transmit side
	task automatic send_frame(input bit is_rx, input int len, input bit bad);
		int sent;
		bit vld;
		bit rdy;
		bit last;
		sent = 0;
		while (sent < len) begin
			@(negedge clk);
			vld = ($urandom % 5) != 0;
			rdy = ($urandom % 4) != 0;
			last = sent == len - 1;
			if (is_rx) begin
				axis_rx_tvalid = vld;
				axis_rx_tlast = last;
				axis_rx_tuser = bad && last;
				if (vld) sent++;
			end else begin
				axis_tx_tvalid = vld;
				axis_tx_tready = rdy;
				axis_tx_tlast = last;
				axis_tx_tuser = bad && last;
				if (vld && rdy) sent++;
			end
		end
		@(negedge clk);
		axis_rx_tvalid = 1'b0;
		axis_tx_tvalid = 1'b0;
		axis_tx_tready = 1'b0;
		// Time for the totals and the logger to settle
		repeat (4) @(negedge clk);
	endtask

	// A beat moves on the next rising edge when both are high here
	task automatic take_beat(output logic [log_width-1:0] data, output logic last);
		int waited;
		bit done;
		waited = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			m_axis_log_tready = ($urandom % 3) != 0;
			if (m_axis_log_tvalid && m_axis_log_tready) begin
				data = m_axis_log_tdata;
				last = m_axis_log_tlast;
				done = 1'b1;
			end else begin
				waited++;
				if (waited > wait_limit) give_up("log stream beat");
			end
		end
	endtask

	task automatic log_record(input string name);
		logic [log_width-1:0] data;
		logic last;
		int i;
		for (i = 0; i < 8; i++) begin
			take_beat(data, last);
			if (i == 1) begin
				check({name, " time order"}, 1, data >= last_time);
				last_time = data;
			end else begin
				check($sformatf("%s beat %0d", name, i), beat_exp[i], data);
			end
			check($sformatf("%s tlast %0d", name, i), i == 7, last);
		end
		@(negedge clk);
		m_axis_log_tready = 1'b0;
	endtask

	// Preload tx bytes right after a clear
	task automatic preset_bytes(input string name, input logic [stat_width-1:0] base);
		preset_value = base;
		reg_write(name, addr_ctrl, 32'h3);
		force i_dut.tx_stats.total_bytes = preset_value;
		repeat (2) @(negedge clk);
		release i_dut.tx_stats.total_bytes;
	endtask

	initial begin
		int fd;
		int line_no;
		int fields;
		int count;
		int bad;
		string line;
		string cmd;
		string name;
		logic [63:0] addr;
		logic [63:0] data;
		logic [63:0] resp;
		void'($urandom(12454));
		reset = 1'b1;
		s_axi_awaddr = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wstrb = '1;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b0;
		s_axi_araddr = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b0;
		m_axis_log_tready = 1'b0;
		axis_tx_tready = 1'b0;
		axis_tx_tvalid = 1'b0;
		axis_tx_tlast = 1'b0;
		axis_tx_tuser = 1'b0;
		axis_rx_tvalid = 1'b0;
		axis_rx_tlast = 1'b0;
		axis_rx_tuser = 1'b0;
		last_time = '0;
		preset_value = '0;
		repeat (16) @(negedge clk);
		reset = 1'b0;

		fd = $fopen("verif/eth_stats_trace.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the trace file verif/eth_stats_trace.txt");
			stop_run();
		end
		line_no = 0;
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			line_no++;
			if (line.len() < 2 || line.substr(0, 0) == "#") continue;
			void'($sscanf(line, "%s", cmd));
			name = $sformatf("line %0d %s", line_no, cmd);
			case (cmd)
				"tx", "rx": begin
					fields = $sscanf(line, "%s %d %d", cmd, count, bad);
					need_fields(fields, 3, line_no);
					send_frame(cmd == "rx", count, bad != 0);
				end
				"wr": begin
					fields = $sscanf(line, "%s %h %h", cmd, addr, data);
					need_fields(fields, 3, line_no);
					reg_write(name, addr[11:0], data[31:0]);
				end
				"rd": begin
					fields = $sscanf(line, "%s %h %h %h", cmd, addr, data, resp);
					need_fields(fields, 4, line_no);
					reg_read(name, addr[11:0], data[31:0], resp[1:0]);
				end
				"log": begin
					fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h", cmd,
						beat_exp[0], beat_exp[1], beat_exp[2], beat_exp[3],
						beat_exp[4], beat_exp[5], beat_exp[6], beat_exp[7]);
					need_fields(fields, 9, line_no);
					log_record(name);
				end
				"idle": begin
					fields = $sscanf(line, "%s %d", cmd, count);
					need_fields(fields, 2, line_no);
					repeat (count) @(negedge clk);
				end
				"preset": begin
					fields = $sscanf(line, "%s %h", cmd, data);
					need_fields(fields, 2, line_no);
					preset_bytes(name, data);
				end
				default: begin
					$display("Unknown trace command on line %0d: %s", line_no, cmd);
					stop_run();
				end
			endcase
		end
		$fclose(fd);
		repeat (4) @(negedge clk);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
hdl/eth_stats_pkg.sv
hdl/axil_pkg.sv
hdl/eth_stats_if.sv
hdl/eth_frame_meter.sv
hdl/eth_stats_accum.sv
hdl/eth_stats_regs.sv
hdl/eth_stats_logger.sv
hdl/eth_stats_collector.sv
verif/eth_stats_tb.sv

/* verif/eth_stats_trace.txt */
# tx|rx <beats> <bad>, wr <addr> <data>, rd <addr> <data> <resp>, idle <cycles>, preset <tx bytes>
# log <header> <time> <tx bytes> <tx good> <tx bad> <rx bytes> <rx good> <rx bad>, time not compared
idle 4
rd 000 0 0
rd 004 0 0
rd 008 0 0
rd 00c 0 0
rd 010 0 0
rd 014 0 0
rd 03c 0 0
rd 040 0 2
tx 50 0
rx 60 1
rd 010 0 0
rd 038 0 0
wr 000 1
tx 64 0
tx 100 1
tx 72 0
rx 64 0
rx 80 0
rx 90 1
rd 010 ec 0
rd 014 0 0
rd 018 2 0
rd 020 1 0
rd 028 ea 0
rd 030 2 0
rd 038 1 0
wr 008 abcd
wr 000 5
tx 40 0
log abcd000000000000 0 114 3 1 ea 2 1
rx 30 1
log abcd000000000000 0 114 3 1 108 2 2
# Log sink stalled, later changes are dropped
tx 20 0
tx 20 1
rx 20 0
rd 00c 2 0
log abcd000000000000 0 128 4 1 108 2 2
tx 10 0
log abcd000000000002 0 146 5 2 11c 3 2
wr 000 3
rd 00c 0 0
rd 010 0 0
rd 038 0 0
preset ffffff00
tx 300 0
rd 010 2c 0
rd 014 1 0
rd 018 1 0
